// ==== rtl/panel_pkg.sv ====
// ======================================================================
// Panel controller shared types
// ======================================================================
`default_nettype none

package panel_pkg;

    typedef logic [4:0]  row_addr_t;      // Up to 32 rows
    typedef logic [5:0]  col_addr_t;      // Up to 64 columns
    typedef logic [5:0]  row_count_t;     // Height of up to a full 32 rows
    typedef logic [6:0]  col_count_t;     // Width of up to a full 64 columns
    typedef logic [1:0]  chan_sel_t;
    typedef logic [23:0] color_t;         // Red in the top byte
    typedef logic [7:0]  channel_byte_t;

    // ==================================================================
    // Colour channels
    // ==================================================================
    localparam int CHAN_COUNT = 3;

    localparam chan_sel_t CHAN_RED   = 2'd0;
    localparam chan_sel_t CHAN_GREEN = 2'd1;
    localparam chan_sel_t CHAN_BLUE  = 2'd2; // Last channel of a pixel

    // ==================================================================
    // Host commands
    // ==================================================================
    typedef enum logic [0:0] {
        CMD_BLANK     = 1'b0,
        CMD_FILL_RECT = 1'b1
    } cmd_op_t;

endpackage

`default_nettype wire

// ==== rtl/fill_area_engine.sv ====
// ======================================================================
// Fill area engine
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module fill_area_engine #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   enable,
    input  wire logic                   ack,
    input  wire panel_pkg::col_addr_t   x1,
    input  wire panel_pkg::row_addr_t   y1,
    input  wire panel_pkg::col_count_t  width,
    input  wire panel_pkg::row_count_t  height,
    input  wire panel_pkg::color_t      color,
    output panel_pkg::row_addr_t        wr_row,
    output panel_pkg::col_addr_t        wr_col,
    output panel_pkg::chan_sel_t        wr_chan,
    output panel_pkg::channel_byte_t    wr_data,
    output logic                        wr_enable,
    output logic                        done
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_DONE
    } fill_state_t;

    fill_state_t state;

    logic [7:0] col_sum;
    logic [6:0] row_sum;
    col_count_t col_lim;
    row_count_t row_lim;
    logic       area_empty;

    col_addr_t  x_start;
    col_count_t col_lim_q;
    row_count_t row_lim_q;
    color_t     color_q;
    row_addr_t  cur_row;
    col_addr_t  cur_col;
    chan_sel_t  cur_chan;
    logic       last_col;
    logic       last_row;

    // ==================================================================
    // Clip the end corner to the panel
    // ==================================================================
    assign col_sum = 8'(x1) + 8'(width);
    assign row_sum = 7'(y1) + 7'(height);
    assign col_lim = (col_sum > 8'(PANEL_WIDTH)) ? col_count_t'(PANEL_WIDTH) : col_sum[6:0];
    assign row_lim = (row_sum > 7'(PANEL_HEIGHT)) ? row_count_t'(PANEL_HEIGHT) : row_sum[5:0];
    assign area_empty = (col_count_t'(x1) >= col_lim) || (row_count_t'(y1) >= row_lim);

    assign last_col = (col_count_t'(cur_col) + 7'd1) == col_lim_q;
    assign last_row = (row_count_t'(cur_row) + 6'd1) == row_lim_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (enable) begin
                        state <= area_empty ? S_DONE : S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (cur_chan == CHAN_BLUE && last_col && last_row) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (ack) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Walk counters with channel fastest, then column, then row
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            x_start   <= x1;
            col_lim_q <= col_lim;
            row_lim_q <= row_lim;
            color_q   <= color;
            cur_row   <= y1;
            cur_col   <= x1;
            cur_chan  <= CHAN_RED;
        end else if (state == S_WRITE) begin
            if (cur_chan == CHAN_BLUE) begin
                cur_chan <= CHAN_RED;
                if (last_col) begin
                    cur_col <= x_start;
                    cur_row <= cur_row + 5'd1;
                end else begin
                    cur_col <= cur_col + 6'd1;
                end
            end else begin
                cur_chan <= cur_chan + 2'd1;
            end
        end
    end

    assign wr_row    = cur_row;
    assign wr_col    = cur_col;
    assign wr_chan   = cur_chan;
    assign wr_enable = (state == S_WRITE);
    assign done      = (state == S_DONE);

    always_comb begin
        case (cur_chan)
            CHAN_RED:   wr_data = color_q[23:16];
            CHAN_GREEN: wr_data = color_q[15:8];
            default:    wr_data = color_q[7:0];
        endcase
    end

    a_write_in_panel: assert property (@(posedge clk) disable iff (reset)
        wr_enable |-> (int'(wr_row) < PANEL_HEIGHT) && (int'(wr_col) < PANEL_WIDTH)
                      && (int'(wr_chan) < CHAN_COUNT))
        else $error("Write outside panel at row %0d col %0d", wr_row, wr_col);

endmodule

`default_nettype wire

// ==== rtl/cmd_blank_panel.sv ====
// ======================================================================
// Blank panel command
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cmd_blank_panel #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                enable,
    output panel_pkg::row_addr_t     wr_row,
    output panel_pkg::col_addr_t     wr_col,
    output panel_pkg::chan_sel_t     wr_chan,
    output panel_pkg::channel_byte_t wr_data,
    output logic                     wr_enable,
    output logic                     done
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        S_START,
        S_RUNNING,
        S_PREDONE,
        S_DONE
    } blank_state_t;

    blank_state_t state;
    logic         local_reset;
    logic         sub_enable;
    logic         sub_done;

    // Enable drops as soon as the engine reports done
    assign sub_enable = (state == S_RUNNING) && !sub_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_START;
            done        <= 1'b0;
            local_reset <= 1'b0;
        end else begin
            case (state)
                S_START: begin
                    if (enable) begin
                        state <= S_RUNNING;
                    end
                end
                S_RUNNING: begin
                    if (sub_done) begin
                        done        <= 1'b1; // Also acks the engine
                        local_reset <= 1'b1;
                        state       <= S_PREDONE;
                    end
                end
                S_PREDONE: begin
                    done        <= 1'b0;
                    local_reset <= 1'b0;
                    state       <= S_DONE;
                end
                S_DONE: begin
                    if (!enable) begin
                        state <= S_START; // Wait for owner to release
                    end
                end
                default: state <= S_START;
            endcase
        end
    end

    fill_area_engine #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) i_fill_area_engine (
        .clk      (clk),
        .reset    (reset || local_reset),
        .enable   (sub_enable),
        .ack      (done),
        .x1       (col_addr_t'(0)),
        .y1       (row_addr_t'(0)),
        .width    (col_count_t'(PANEL_WIDTH)),
        .height   (row_count_t'(PANEL_HEIGHT)),
        .color    (color_t'(0)),    // Black
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .wr_enable(wr_enable),
        .done     (sub_done)
    );

endmodule

`default_nettype wire

// ==== rtl/panel_cmd_dispatch.sv ====
// ======================================================================
// Host command dispatcher
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module panel_cmd_dispatch #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   cmd_valid,
    input  wire panel_pkg::cmd_op_t     cmd_op,
    input  wire panel_pkg::col_addr_t   rect_x,
    input  wire panel_pkg::row_addr_t   rect_y,
    input  wire panel_pkg::col_count_t  rect_width,
    input  wire panel_pkg::row_count_t  rect_height,
    input  wire panel_pkg::color_t      rect_color,
    output logic                        busy,
    output logic                        cmd_done,
    output panel_pkg::row_addr_t        wr_row,
    output panel_pkg::col_addr_t        wr_col,
    output panel_pkg::chan_sel_t        wr_chan,
    output panel_pkg::channel_byte_t    wr_data,
    output logic                        wr_enable
);
    import panel_pkg::*;

    typedef enum logic [2:0] {
        D_IDLE,
        D_BLANK,
        D_RECT,
        D_RECT_ACK,
        D_FINISH
    } disp_state_t;

    disp_state_t   state;

    col_addr_t     rect_x_q;
    row_addr_t     rect_y_q;
    col_count_t    rect_width_q;
    row_count_t    rect_height_q;
    color_t        rect_color_q;

    logic          blank_enable;
    logic          blank_done;
    row_addr_t     blank_wr_row;
    col_addr_t     blank_wr_col;
    chan_sel_t     blank_wr_chan;
    channel_byte_t blank_wr_data;
    logic          blank_wr_enable;

    logic          rect_enable;
    logic          rect_ack;
    logic          rect_done;
    row_addr_t     rect_wr_row;
    col_addr_t     rect_wr_col;
    chan_sel_t     rect_wr_chan;
    channel_byte_t rect_wr_data;
    logic          rect_wr_enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= D_IDLE;
        end else begin
            case (state)
                D_IDLE: begin
                    if (cmd_valid) begin
                        state <= (cmd_op == CMD_BLANK) ? D_BLANK : D_RECT;
                    end
                end
                D_BLANK:    if (blank_done) state <= D_FINISH;
                D_RECT:     if (rect_done) state <= D_RECT_ACK;
                D_RECT_ACK: state <= D_FINISH;
                D_FINISH:   state <= D_IDLE;
                default:    state <= D_IDLE;
            endcase
        end
    end

    // Command fields are only valid with the strobe
    always_ff @(posedge clk) begin
        if (state == D_IDLE && cmd_valid) begin
            rect_x_q      <= rect_x;
            rect_y_q      <= rect_y;
            rect_width_q  <= rect_width;
            rect_height_q <= rect_height;
            rect_color_q  <= rect_color;
        end
    end

    assign busy         = (state != D_IDLE);
    assign cmd_done     = (state == D_FINISH);
    assign blank_enable = (state == D_BLANK);
    assign rect_enable  = (state == D_RECT) && !rect_done;
    assign rect_ack     = (state == D_RECT_ACK);

    cmd_blank_panel #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) i_cmd_blank_panel (
        .clk      (clk),
        .reset    (reset),
        .enable   (blank_enable),
        .wr_row   (blank_wr_row),
        .wr_col   (blank_wr_col),
        .wr_chan  (blank_wr_chan),
        .wr_data  (blank_wr_data),
        .wr_enable(blank_wr_enable),
        .done     (blank_done)
    );

    fill_area_engine #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) i_rect_engine (
        .clk      (clk),
        .reset    (reset),
        .enable   (rect_enable),
        .ack      (rect_ack),
        .x1       (rect_x_q),
        .y1       (rect_y_q),
        .width    (rect_width_q),
        .height   (rect_height_q),
        .color    (rect_color_q),
        .wr_row   (rect_wr_row),
        .wr_col   (rect_wr_col),
        .wr_chan  (rect_wr_chan),
        .wr_data  (rect_wr_data),
        .wr_enable(rect_wr_enable),
        .done     (rect_done)
    );

    // ==================================================================
    // RAM write port mux
    // ==================================================================
    assign wr_enable = blank_wr_enable || rect_wr_enable;
    assign wr_row    = blank_wr_enable ? blank_wr_row  : rect_wr_row;
    assign wr_col    = blank_wr_enable ? blank_wr_col  : rect_wr_col;
    assign wr_chan   = blank_wr_enable ? blank_wr_chan : rect_wr_chan;
    assign wr_data   = blank_wr_enable ? blank_wr_data : rect_wr_data;

    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        !(blank_wr_enable && rect_wr_enable))
        else $error("Blank and rectangle engines write in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
// ======================================================================
// Frame buffer RAM
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire logic                     clk,
    input  wire logic                     wr_enable,
    input  wire panel_pkg::row_addr_t     wr_row,
    input  wire panel_pkg::col_addr_t     wr_col,
    input  wire panel_pkg::chan_sel_t     wr_chan,
    input  wire panel_pkg::channel_byte_t wr_data,
    input  wire panel_pkg::row_addr_t     rd_row,
    input  wire panel_pkg::col_addr_t     rd_col,
    input  wire panel_pkg::chan_sel_t     rd_chan,
    output panel_pkg::channel_byte_t      rd_data
);
    import panel_pkg::*;

    localparam int DEPTH  = PANEL_WIDTH * PANEL_HEIGHT * CHAN_COUNT;
    localparam int ADDR_W = $clog2(DEPTH);

    channel_byte_t     mem [DEPTH];
    logic [ADDR_W-1:0] wr_index;
    logic [ADDR_W-1:0] rd_index;

    // Pixels stored row major with three bytes each
    function automatic logic [ADDR_W-1:0] flat_index(
        input row_addr_t row,
        input col_addr_t col,
        input chan_sel_t chan
    );
        int unsigned idx;
        idx = (int'(row) * PANEL_WIDTH + int'(col)) * CHAN_COUNT + int'(chan);
        return ADDR_W'(idx);
    endfunction

    assign wr_index = flat_index(wr_row, wr_col, wr_chan);
    assign rd_index = flat_index(rd_row, rd_col, rd_chan);

    always_ff @(posedge clk) begin
        if (wr_enable) begin
            mem[wr_index] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index]; // One cycle read latency
    end

endmodule

`default_nettype wire

// ==== rtl/panel_ctrl_top.sv ====
// ======================================================================
// LED panel controller top level
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   cmd_valid,
    input  wire panel_pkg::cmd_op_t     cmd_op,
    input  wire panel_pkg::col_addr_t   rect_x,
    input  wire panel_pkg::row_addr_t   rect_y,
    input  wire panel_pkg::col_count_t  rect_width,
    input  wire panel_pkg::row_count_t  rect_height,
    input  wire panel_pkg::color_t      rect_color,
    output logic                        busy,
    output logic                        cmd_done,
    input  wire panel_pkg::row_addr_t   rd_row,
    input  wire panel_pkg::col_addr_t   rd_col,
    input  wire panel_pkg::chan_sel_t   rd_chan,
    output panel_pkg::channel_byte_t    rd_data
);
    import panel_pkg::*;

    row_addr_t     wr_row;
    col_addr_t     wr_col;
    chan_sel_t     wr_chan;
    channel_byte_t wr_data;
    logic          wr_enable;

    panel_cmd_dispatch #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) i_panel_cmd_dispatch (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .rect_x     (rect_x),
        .rect_y     (rect_y),
        .rect_width (rect_width),
        .rect_height(rect_height),
        .rect_color (rect_color),
        .busy       (busy),
        .cmd_done   (cmd_done),
        .wr_row     (wr_row),
        .wr_col     (wr_col),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .wr_enable  (wr_enable)
    );

    frame_buffer #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) i_frame_buffer (
        .clk      (clk),
        .wr_enable(wr_enable),
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_chan  (rd_chan),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// ==== verification/panel_ctrl_tb.sv ====
// ======================================================================
// Panel controller testbench
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_tb;
    import panel_pkg::*;

    localparam int PANEL_WIDTH  = 16;
    localparam int PANEL_HEIGHT = 8;
    localparam int NUM_CMDS     = 8;
    localparam int FULL_BYTES   = PANEL_WIDTH * PANEL_HEIGHT * CHAN_COUNT;
    localparam int CYCLE_LIMIT  = 4 * NUM_CMDS * (3 * FULL_BYTES + 400);

    logic          clk = 1'b0;
    logic          reset;
    logic          cmd_valid;
    cmd_op_t       cmd_op;
    col_addr_t     rect_x;
    row_addr_t     rect_y;
    col_count_t    rect_width;
    row_count_t    rect_height;
    color_t        rect_color;
    logic          busy;
    logic          cmd_done;
    row_addr_t     rd_row;
    col_addr_t     rd_col;
    chan_sel_t     rd_chan;
    channel_byte_t rd_data;

    // Command table
    cmd_op_t     tbl_op    [NUM_CMDS];
    int          tbl_x     [NUM_CMDS];
    int          tbl_y     [NUM_CMDS];
    int          tbl_w     [NUM_CMDS];
    int          tbl_h     [NUM_CMDS];
    logic [23:0] tbl_color [NUM_CMDS];
    logic        tbl_extra [NUM_CMDS];   // Second strobe while busy
    int          tbl_count;

    logic [7:0]  model [PANEL_HEIGHT][PANEL_WIDTH][CHAN_COUNT];
    logic [31:0] rng_state;
    int          cycle_count = 0;

    panel_ctrl_top #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) i_panel_ctrl_top (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .rect_x     (rect_x),
        .rect_y     (rect_y),
        .rect_width (rect_width),
        .rect_height(rect_height),
        .rect_color (rect_color),
        .busy       (busy),
        .cmd_done   (cmd_done),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .rd_chan    (rd_chan),
        .rd_data    (rd_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Simulation FAILED");
            $fatal(1, "Timeout, the DUT did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic add_command(input cmd_op_t op, input int x, input int y,
                               input int w, input int h, input logic extra);
        rng_state             = next_random(rng_state);
        tbl_op[tbl_count]     = op;
        tbl_x[tbl_count]      = x;
        tbl_y[tbl_count]      = y;
        tbl_w[tbl_count]      = w;
        tbl_h[tbl_count]      = h;
        tbl_color[tbl_count]  = rng_state[23:0];
        tbl_extra[tbl_count]  = extra;
        tbl_count             = tbl_count + 1;
    endtask

    // Expected frame after a command with clipping to the panel
    task automatic update_model(input int idx);
        for (int r = 0; r < PANEL_HEIGHT; r++) begin
            for (int c = 0; c < PANEL_WIDTH; c++) begin
                if (tbl_op[idx] == CMD_BLANK) begin
                    model[r][c][0] = 8'h00;
                    model[r][c][1] = 8'h00;
                    model[r][c][2] = 8'h00;
                end else if (r >= tbl_y[idx] && r < tbl_y[idx] + tbl_h[idx]
                             && c >= tbl_x[idx] && c < tbl_x[idx] + tbl_w[idx]) begin
                    model[r][c][0] = tbl_color[idx][23:16];
                    model[r][c][1] = tbl_color[idx][15:8];
                    model[r][c][2] = tbl_color[idx][7:0];
                end
            end
        end
    endtask

    task automatic run_command(input int idx);
        int waited;
        waited      = 0;
        cmd_op      = tbl_op[idx];
        rect_x      = col_addr_t'(tbl_x[idx]);
        rect_y      = row_addr_t'(tbl_y[idx]);
        rect_width  = col_count_t'(tbl_w[idx]);
        rect_height = row_count_t'(tbl_h[idx]);
        rect_color  = tbl_color[idx];
        cmd_valid   = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        compare_value("busy", 32'(busy), 32'd1);
        while (cmd_done !== 1'b1) begin
            if (tbl_extra[idx] && waited == 2) begin
                cmd_op    = CMD_BLANK;    // Would clear the frame if accepted
                cmd_valid = 1'b1;
            end
            @(negedge clk);
            cmd_valid = 1'b0;
            compare_value("busy", 32'(busy), 32'd1);
            waited = waited + 1;
        end
        @(negedge clk);
        compare_value("cmd_done", 32'(cmd_done), 32'd0);
        compare_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic compare_frame();
        for (int r = 0; r < PANEL_HEIGHT; r++) begin
            for (int c = 0; c < PANEL_WIDTH; c++) begin
                for (int ch = 0; ch < CHAN_COUNT; ch++) begin
                    rd_row  = row_addr_t'(r);
                    rd_col  = col_addr_t'(c);
                    rd_chan = chan_sel_t'(ch);
                    @(negedge clk);
                    compare_value($sformatf("rd_data[%0d][%0d][%0d]", r, c, ch),
                                  32'(rd_data), 32'(model[r][c][ch]));
                end
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_op      = CMD_BLANK;
        rect_x      = '0;
        rect_y      = '0;
        rect_width  = '0;
        rect_height = '0;
        rect_color  = '0;
        rd_row      = '0;
        rd_col      = '0;
        rd_chan     = '0;
        rng_state   = 32'h934b_3353;
        tbl_count   = 0;

        // ==============================================================
        // Command table with op, x, y, width, height and extra strobe
        // ==============================================================
        add_command(CMD_BLANK,      0, 0,  0, 0, 1'b0);
        add_command(CMD_FILL_RECT,  2, 1,  4, 3, 1'b0);
        add_command(CMD_FILL_RECT, 12, 5,  8, 6, 1'b0);   // Clipped right and bottom
        add_command(CMD_FILL_RECT,  3, 3,  0, 2, 1'b0);   // Zero width
        add_command(CMD_FILL_RECT,  5, 0,  3, 0, 1'b0);   // Zero height
        add_command(CMD_FILL_RECT,  0, 0, 16, 8, 1'b1);
        add_command(CMD_FILL_RECT, 10, 2,  3, 4, 1'b0);
        add_command(CMD_BLANK,      0, 0,  0, 0, 1'b0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_value("busy", 32'(busy), 32'd0);
        compare_value("cmd_done", 32'(cmd_done), 32'd0);

        for (int i = 0; i < tbl_count; i++) begin
            update_model(i);
            run_command(i);
            compare_frame();
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/panel_pkg.sv
rtl/fill_area_engine.sv
rtl/cmd_blank_panel.sv
rtl/panel_cmd_dispatch.sv
rtl/frame_buffer.sv
rtl/panel_ctrl_top.sv
verification/panel_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the panel controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module panel_ctrl_tb \
    -f tb.f -o panel_ctrl_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/panel_ctrl_tb_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation binary returned status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Simulation PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
